// File: rtl/tx_queue_pkg.sv
// TX queue package: byte width, FIFO entry types and controller states

package tx_queue_pkg;

   //////////////////////////////////////////////////////////////////////
   // Stream width
   //////////////////////////////////////////////////////////////////////

   // Fixed for the 1G byte-wide MAC interface
   localparam int byte_width = 8;

   //////////////////////////////////////////////////////////////////////
   // FIFO entries
   //////////////////////////////////////////////////////////////////////

   // One data FIFO entry, 9 bits
   typedef struct packed {
      logic                  eop;
      logic [byte_width-1:0] data;
   } tx_word_t;

   // One marker per complete packet
   typedef struct packed {
      logic done;
   } pkt_mark_t;

   //////////////////////////////////////////////////////////////////////
   // Controller
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      st_idle,
      st_wait_ack,
      st_send,
      st_gap
   } tx_state_t;

endpackage

// File: rtl/async_fifo.sv
// Dual-clock FWFT FIFO with gray-coded pointers and an almost-full flag

module async_fifo #(
   parameter type payload_t          = logic [7:0],
   parameter int  addr_width         = 4,
   parameter int  almost_full_margin = 2
) (
   input  logic     wr_clk,
   input  logic     rd_clk,
   input  logic     reset,
   // Write side
   input  logic     wr_en,
   input  payload_t wr_data,
   output logic     almost_full,
   output logic     full,
   // Read side
   input  logic     rd_en,
   output payload_t rd_data,
   output logic     empty
);

   localparam int depth = 1 << addr_width;
   localparam int ptr_w = addr_width + 1;

   // Fill level at which almost_full rises
   localparam logic [ptr_w-1:0] af_level = ptr_w'(depth - almost_full_margin);

   payload_t mem [depth];

   logic [ptr_w-1:0] wr_bin;
   logic [ptr_w-1:0] wr_gray;
   logic [ptr_w-1:0] wr_bin_next;
   logic [ptr_w-1:0] rd_bin;
   logic [ptr_w-1:0] rd_gray;
   logic [ptr_w-1:0] rd_bin_next;

   // Gray pointers after crossing
   logic [ptr_w-1:0] rd_gray_w1;
   logic [ptr_w-1:0] rd_gray_w2;
   logic [ptr_w-1:0] wr_gray_r1;
   logic [ptr_w-1:0] wr_gray_r2;

   logic [ptr_w-1:0] rd_bin_w;
   logic [ptr_w-1:0] wr_used;
   logic             wr_inc;
   logic             rd_inc;

   function automatic logic [ptr_w-1:0] gray2bin(input logic [ptr_w-1:0] g);
      logic [ptr_w-1:0] b;
      b[ptr_w-1] = g[ptr_w-1];
      for (int i = ptr_w - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Write domain
   //////////////////////////////////////////////////////////////////////

   assign wr_inc      = wr_en & ~full;
   assign wr_bin_next = wr_bin + 1'b1;

   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset) begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end else if (wr_inc) begin
         wr_bin  <= wr_bin_next;
         wr_gray <= (wr_bin_next >> 1) ^ wr_bin_next;
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_inc) begin
         mem[wr_bin[addr_width-1:0]] <= wr_data;
      end
   end

   // Read pointer into the write clock
   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset) begin
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
      end else begin
         rd_gray_w1 <= rd_gray;
         rd_gray_w2 <= rd_gray_w1;
      end
   end

   // Fill level seen from the write side, pessimistic by the sync delay
   assign rd_bin_w    = gray2bin(rd_gray_w2);
   assign wr_used     = wr_bin - rd_bin_w;
   assign full        = wr_used[addr_width];
   assign almost_full = (wr_used >= af_level);

   //////////////////////////////////////////////////////////////////////
   // Read domain
   //////////////////////////////////////////////////////////////////////

   assign rd_inc      = rd_en & ~empty;
   assign rd_bin_next = rd_bin + 1'b1;

   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset) begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end else if (rd_inc) begin
         rd_bin  <= rd_bin_next;
         rd_gray <= (rd_bin_next >> 1) ^ rd_bin_next;
      end
   end

   // Write pointer into the read clock
   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset) begin
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end else begin
         wr_gray_r1 <= wr_gray;
         wr_gray_r2 <= wr_gray_r1;
      end
   end

   assign empty = (rd_gray == wr_gray_r2);

   // First word falls through
   assign rd_data = mem[rd_bin[addr_width-1:0]];

   // Callers must respect the flags
   wr_no_overflow: assert property (
      @(posedge wr_clk) disable iff (reset) wr_en |-> !full
   ) else $error("async_fifo: write while full");

   rd_no_underflow: assert property (
      @(posedge rd_clk) disable iff (reset) rd_en |-> !empty
   ) else $error("async_fifo: read while empty");

endmodule

// File: rtl/axis_tx_ingress.sv
// AXI-Stream ingress: handshake, FIFO word packing and packet markers

module axis_tx_ingress (
   input  logic                                 clk,
   input  logic                                 reset,
   // AXI-Stream slave
   input  logic [tx_queue_pkg::byte_width-1:0]  tdata,
   input  logic                                 tvalid,
   input  logic                                 tlast,
   output logic                                 tready,
   // Data FIFO write port
   input  logic                                 fifo_almost_full,
   output logic                                 wr_en,
   output tx_queue_pkg::tx_word_t               wr_data,
   // Marker FIFO write port
   output logic                                 mark_wr_en,
   output tx_queue_pkg::pkt_mark_t              mark_data
);

   import tx_queue_pkg::*;

   tx_word_t beat;
   logic     accept;

   // Keep a margin so beats in flight still fit
   assign tready = ~fifo_almost_full;
   assign accept = tvalid & tready;

   assign beat.eop  = tlast;
   assign beat.data = tdata;

   assign wr_en   = accept;
   assign wr_data = beat;

   // One marker only for a last beat that was really taken
   assign mark_wr_en     = accept & tlast;
   assign mark_data.done = 1'b1;

   // AXI rule: a stalled beat is held by the sender
   axis_hold: assert property (
      @(posedge clk) disable iff (reset)
      (tvalid && !tready) |=> (tvalid && $stable(tdata) && $stable(tlast))
   ) else $error("axis_tx_ingress: beat changed while stalled");

endmodule

// File: rtl/tx_queue_ctrl.sv
// TX controller: packet start, MAC acknowledge, byte streaming and frame gap

module tx_queue_ctrl (
   input  logic                   clk125,
   input  logic                   reset,
   // Marker FIFO read port
   input  logic                   mark_empty,
   output logic                   mark_rd_en,
   // Data FIFO read port
   input  tx_queue_pkg::tx_word_t rd_data,
   input  logic                   data_empty,
   output logic                   rd_en,
   // MAC side
   output logic [7:0]             tx_data,
   output logic                   tx_data_valid,
   input  logic                   tx_ack
);

   import tx_queue_pkg::*;

   tx_state_t state;
   tx_state_t state_next;

   //////////////////////////////////////////////////////////////////////
   // Next state and outputs
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_next    = state;
      mark_rd_en    = 1'b0;
      rd_en         = 1'b0;
      tx_data_valid = 1'b0;

      case (state)
         st_idle: begin
            // A marker means the whole packet is already readable
            if (!mark_empty) begin
               mark_rd_en = 1'b1;
               state_next = st_wait_ack;
            end
         end

         st_wait_ack: begin
            // First byte held until the MAC takes it
            tx_data_valid = ~data_empty;
            if (tx_ack) begin
               rd_en = 1'b1;
               // Single-byte frame ends right here
               state_next = rd_data.eop ? st_gap : st_send;
            end
         end

         st_send: begin
            tx_data_valid = ~data_empty;
            rd_en         = 1'b1;
            if (rd_data.eop) begin
               state_next = st_gap;
            end
         end

         st_gap: begin
            state_next = st_idle;
         end

         default: begin
            state_next = st_idle;
         end
      endcase
   end

   assign tx_data = rd_data.data;

   always_ff @(posedge clk125 or posedge reset) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Marker and data cross the same way, so a started frame never runs dry
   no_underrun: assert property (
      @(posedge clk125) disable iff (reset) (state == st_send) |-> !data_empty
   ) else $error("tx_queue_ctrl: data FIFO empty inside a frame");

   // A marker is only taken once its frame is readable
   frame_ready: assert property (
      @(posedge clk125) disable iff (reset) mark_rd_en |-> !data_empty
   ) else $error("tx_queue_ctrl: marker seen before its data");

endmodule

// File: rtl/tx_queue.sv
// TX queue top: AXI-Stream in, clock crossing, byte stream out to the MAC

module tx_queue #(
   parameter int data_addr_width = 11,
   parameter int mark_addr_width = 6,
   parameter int af_margin       = 10
) (
   input  logic                                clk,
   input  logic                                clk125,
   input  logic                                reset,
   // AXI-Stream side, clk
   input  logic [tx_queue_pkg::byte_width-1:0] tdata,
   input  logic                                tvalid,
   input  logic                                tlast,
   output logic                                tready,
   // MAC side, clk125
   output logic [7:0]                          tx_data,
   output logic                                tx_data_valid,
   input  logic                                tx_ack
);

   import tx_queue_pkg::*;

   // Data path
   tx_word_t  data_wr;
   tx_word_t  data_rd;
   logic      data_wr_en;
   logic      data_af;
   logic      data_rd_en;
   logic      data_empty;

   // Packet markers
   pkt_mark_t mark_wr;
   logic      mark_wr_en;
   logic      mark_rd_en;
   logic      mark_empty;

   axis_tx_ingress u_ingress (
      .clk              (clk),
      .reset            (reset),
      .tdata            (tdata),
      .tvalid           (tvalid),
      .tlast            (tlast),
      .tready           (tready),
      .fifo_almost_full (data_af),
      .wr_en            (data_wr_en),
      .wr_data          (data_wr),
      .mark_wr_en       (mark_wr_en),
      .mark_data        (mark_wr)
   );

   async_fifo #(
      .payload_t          (tx_word_t),
      .addr_width         (data_addr_width),
      .almost_full_margin (af_margin)
   ) u_data_fifo (
      .wr_clk      (clk),
      .rd_clk      (clk125),
      .reset       (reset),
      .wr_en       (data_wr_en),
      .wr_data     (data_wr),
      .almost_full (data_af),
      .full        (),
      .rd_en       (data_rd_en),
      .rd_data     (data_rd),
      .empty       (data_empty)
   );

   // Only the presence of a marker matters on the read side
   async_fifo #(
      .payload_t          (pkt_mark_t),
      .addr_width         (mark_addr_width),
      .almost_full_margin (af_margin)
   ) u_mark_fifo (
      .wr_clk      (clk),
      .rd_clk      (clk125),
      .reset       (reset),
      .wr_en       (mark_wr_en),
      .wr_data     (mark_wr),
      .almost_full (),
      .full        (),
      .rd_en       (mark_rd_en),
      .rd_data     (),
      .empty       (mark_empty)
   );

   tx_queue_ctrl u_ctrl (
      .clk125        (clk125),
      .reset         (reset),
      .mark_empty    (mark_empty),
      .mark_rd_en    (mark_rd_en),
      .rd_data       (data_rd),
      .data_empty    (data_empty),
      .rd_en         (data_rd_en),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_ack        (tx_ack)
   );

endmodule

// File: tb/tx_queue_tb.sv
// TX queue testbench: AXI-Stream driver, MAC model with scoreboard, directed tests

module tx_queue_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import tx_queue_pkg::*;

   logic                  clk = 1'b0;
   logic                  clk125 = 1'b0;
   logic                  reset;
   logic [byte_width-1:0] tdata;
   logic                  tvalid;
   logic                  tlast;
   logic                  tready;
   logic [7:0]            tx_data;
   logic                  tx_data_valid;
   logic                  tx_ack = 1'b0;

   // Scoreboard and MAC model state
   logic [7:0]  exp_q[$];
   int          len_q[$];
   int          ack_q[$];
   int          ack_delay;
   logic        in_frame;
   logic        acked;
   logic [7:0]  hold_byte;
   int          hold_delay;
   int          hold_good;
   int          delay_cnt;
   int          frame_left;
   int          low_run;
   int          frames_seen;
   // Cycles of the last frame with the first byte valid and unchanged up to the ack
   int          last_hold;
   int          mon_errors;

   // Driver and test bookkeeping
   logic [31:0] lfsr = 32'h6275_b496;
   int          errors;
   int          stall_cycles;
   logic        timed_out;
   int          tests_ok;
   int          tests_bad;

   tx_queue #(
      .data_addr_width (11),
      .mark_addr_width (6),
      .af_margin       (10)
   ) DUT (
      .clk           (clk),
      .clk125        (clk125),
      .reset         (reset),
      .tdata         (tdata),
      .tvalid        (tvalid),
      .tlast         (tlast),
      .tready        (tready),
      .tx_data       (tx_data),
      .tx_data_valid (tx_data_valid),
      .tx_ack        (tx_ack)
   );

   always #2 clk = ~clk;
   always #4 clk125 = ~clk125;

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic int total_errors();
      return errors + mon_errors;
   endfunction

   ////////////////////////////////////////////////////////////////////
   // MAC model and scoreboard, clk125 falling edge
   ////////////////////////////////////////////////////////////////////

   task take_byte();
      logic [7:0] exp;
      if (exp_q.size() == 0) begin
         $display("Byte %02h at %0t arrived with nothing left to send", tx_data, $time);
         mon_errors++;
      end else begin
         exp = exp_q.pop_front();
         if (tx_data !== exp) begin
            $display("ERROR t=%0t tx_data expected %02h got %02h", $time, exp, tx_data);
            mon_errors++;
         end
      end
      frame_left--;
      if (frame_left <= 0) begin
         in_frame = 1'b0;
         acked    = 1'b0;
         low_run  = 0;
         frames_seen++;
      end
   endtask

   always @(negedge clk125) begin
      tx_ack = 1'b0;
      if (reset) begin
         in_frame    = 1'b0;
         acked       = 1'b0;
         low_run     = 2;
         frames_seen = 0;
         mon_errors  = 0;
      end else begin
         // Rise of valid opens a frame
         if (!in_frame) begin
            if (tx_data_valid) begin
               if (low_run < 2) begin
                  $display("ERROR t=%0t gap_cycles expected >=2 got %0d", $time, low_run);
                  mon_errors++;
               end
               if (len_q.size() == 0) begin
                  $display("Frame started at %0t with no packet queued", $time);
                  mon_errors++;
                  frame_left = 1;
               end else begin
                  frame_left = len_q.pop_front();
               end
               hold_byte  = tx_data;
               hold_delay = (ack_q.size() > 0) ? ack_q.pop_front() : ack_delay;
               hold_good  = 0;
               delay_cnt  = 0;
               in_frame   = 1'b1;
               acked      = 1'b0;
            end else begin
               low_run++;
            end
         end
         if (in_frame && !acked) begin
            if (!tx_data_valid) begin
               $display("tx_data_valid dropped at %0t before the ack", $time);
               mon_errors++;
            end else if (tx_data !== hold_byte) begin
               $display("ERROR t=%0t tx_data expected %02h got %02h", $time, hold_byte, tx_data);
               mon_errors++;
            end else begin
               hold_good++;
            end
            if (delay_cnt >= hold_delay) begin
               tx_ack    = 1'b1;
               acked     = 1'b1;
               last_hold = hold_good;
               take_byte();
            end else begin
               delay_cnt++;
            end
         end else if (in_frame) begin
            if (!tx_data_valid) begin
               $display("tx_data_valid low at %0t inside a frame", $time);
               mon_errors++;
            end else begin
               take_byte();
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // AXI-Stream driver, clk falling edge
   ////////////////////////////////////////////////////////////////////

   task automatic send_beat(input logic [7:0] d, input logic last);
      int waited;
      waited = 0;
      tdata  = d;
      tlast  = last;
      tvalid = 1'b1;
      // tready only moves on a rising edge, so this sample holds for the next one
      while (!tready && !timed_out) begin
         @(negedge clk);
         waited++;
         stall_cycles++;
         if (waited > 20000) begin
            $display("Timeout: tready stayed low for %0d clk cycles", waited);
            timed_out = 1'b1;
         end
      end
      if (!timed_out) begin
         exp_q.push_back(d);
         @(negedge clk);
      end
      tvalid = 1'b0;
      tlast  = 1'b0;
   endtask

   task automatic send_packet(input int len, input logic gaps);
      logic [7:0] d;
      int         idle;
      len_q.push_back(len);
      for (int i = 0; i < len && !timed_out; i++) begin
         if (gaps) begin
            idle = int'(rand_bits(2));
            repeat (idle) @(negedge clk);
         end
         d = 8'(rand_bits(8));
         send_beat(d, i == len - 1);
      end
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while ((exp_q.size() != 0 || len_q.size() != 0 || in_frame) && !timed_out) begin
         @(negedge clk125);
         n++;
         if (n > limit) begin
            $display("Timeout: %0d bytes still undelivered after %0d cycles", exp_q.size(), n);
            timed_out = 1'b1;
         end
      end
      repeat (4) @(negedge clk125);
   endtask

   task automatic report_test(input string name, input int err_before);
      if (total_errors() == err_before && !timed_out) begin
         tests_ok++;
         $display("[%0t] %s: ok", $time, name);
      end else begin
         tests_bad++;
         $display("[%0t] %s: failed, %0d errors", $time, name, total_errors() - err_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////

   task automatic single_packet();
      int e0;
      e0 = total_errors();
      if (tready !== 1'b1) begin
         $display("ERROR t=%0t tready expected 1 got %b", $time, tready);
         errors++;
      end
      if (tx_data_valid !== 1'b0) begin
         $display("ERROR t=%0t tx_data_valid expected 0 got %b", $time, tx_data_valid);
         errors++;
      end
      ack_delay = 2;
      send_packet(64, 1'b0);
      wait_drained(5000);
      report_test("reset state and single 64-byte packet", e0);
   endtask

   task automatic late_ack();
      int e0;
      e0 = total_errors();
      ack_delay = 10;
      send_packet(32, 1'b0);
      wait_drained(5000);
      // Ten wait cycles and the ack cycle itself
      if (last_hold != 11) begin
         $display("ERROR t=%0t last_hold expected 11 got %0d", $time, last_hold);
         errors++;
      end
      report_test("first byte held for a 10-cycle ack delay", e0);
   endtask

   task automatic back_to_back();
      int e0;
      int f0;
      e0 = total_errors();
      f0 = frames_seen;
      ack_delay = 0;
      send_packet(20, 1'b0);
      send_packet(37, 1'b0);
      send_packet(5, 1'b0);
      wait_drained(5000);
      if (frames_seen - f0 != 3) begin
         $display("ERROR t=%0t frames expected 3 got %0d", $time, frames_seen - f0);
         errors++;
      end
      report_test("three back-to-back packets", e0);
   endtask

   task automatic back_pressure();
      int e0;
      e0 = total_errors();
      ack_delay    = 200;
      stall_cycles = 0;
      for (int p = 0; p < 4 && !timed_out; p++) begin
         send_packet(1500, 1'b0);
      end
      wait_drained(100000);
      if (stall_cycles == 0) begin
         $display("tready never dropped while the MAC held off the ack");
         errors++;
      end
      report_test("back-pressure with 1500-byte packets", e0);
   endtask

   task automatic random_traffic();
      int e0;
      int f0;
      int len;
      e0 = total_errors();
      f0 = frames_seen;
      for (int p = 0; p < 20 && !timed_out; p++) begin
         len = int'(rand_bits(11) % 1518) + 1;
         ack_q.push_back(int'(rand_bits(4)));
         send_packet(len, 1'b1);
      end
      wait_drained(200000);
      if (frames_seen - f0 != 20 || ack_q.size() != 0) begin
         $display("Only %0d of 20 random frames came out", frames_seen - f0);
         errors++;
      end
      report_test("20 random packets", e0);
   endtask

   initial begin
      reset        = 1'b1;
      tdata        = '0;
      tvalid       = 1'b0;
      tlast        = 1'b0;
      errors       = 0;
      stall_cycles = 0;
      timed_out    = 1'b0;
      tests_ok     = 0;
      tests_bad    = 0;
      ack_delay    = 0;
      last_hold    = 0;
      hold_good    = 0;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      single_packet();
      if (!timed_out) late_ack();
      if (!timed_out) back_to_back();
      if (!timed_out) back_pressure();
      if (!timed_out) random_traffic();

      $display("Summary: %0d tests ok, %0d failed, %0d errors", tests_ok, tests_bad,
               total_errors());
      if (total_errors() == 0 && tests_bad == 0 && !timed_out) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: list.f
rtl/tx_queue_pkg.sv
rtl/async_fifo.sv
rtl/axis_tx_ingress.sv
rtl/tx_queue_ctrl.sv
rtl/tx_queue.sv
tb/tx_queue_tb.sv

// File: Makefile
TOP = tx_queue_tb

all: run

obj_dir/V$(TOP): list.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

sim.log: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	@grep -q "^STATUS: PASS$$" sim.log || (rm -f sim.log; echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
